// ==== verilog/spi_bridge_pkg.sv ====
`default_nettype none

package spi_bridge_pkg;

  // ************************************************************
  // Frame geometry
  // ************************************************************

  // A three-wire transfer starts with a 16-bit instruction, MSB is R/W
  localparam int INSTR_BITS = 16;

  // Wide enough to hold INSTR_BITS itself, where the counter saturates
  localparam int CNT_W = 5;

  // Host select code when no device is addressed
  localparam logic [2:0] CSN_IDLE = 3'b111;

  localparam int NUM_DEV = 6;

  // ************************************************************
  // Devices on the shared SPI bus
  // ************************************************************

  // Host chip-select code per device, codes 6 and 7 select nothing
  typedef enum logic [2:0] {
    DEV_ADC     = 3'd0,
    DEV_DAC     = 3'd1,
    DEV_CLKDIST = 3'd2,
    DEV_AMP     = 3'd3,
    DEV_PLL     = 3'd4,
    DEV_ATTEN   = 3'd5
  } dev_sel_e;

  // Devices that answer reads on SDIO, indexed by dev_sel_e
  // The amplifier, PLL and attenuator are write-only on this board
  localparam logic [NUM_DEV-1:0] READ_CAPABLE = 6'b000111;

  // ************************************************************
  // Bundles between the blocks
  // ************************************************************

  // Host pins after resynchronization into the system clock
  typedef struct packed {
    logic       clk;
    logic [2:0] csn;
    logic       mosi;
  } spi_pins_t;

  // Single-cycle strobes, edges are only raised inside a frame
  typedef struct packed {
    logic rise;
    logic fall;
    logic start;
    logic stop;
  } spi_evt_t;

endpackage

`default_nettype wire

// ==== verilog/spi_edge_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_edge_sync
  import spi_bridge_pkg::*;
(
  input  wire        sys_clk_i,
  input  wire        arst_n_i,
  input  wire        spi_clk_i,
  input  wire  [2:0] spi_csn_i,
  input  wire        spi_mosi_i,
  output spi_pins_t  pins_o,
  output spi_evt_t   evt_o
);

  spi_pins_t  raw_pins;
  spi_pins_t  sync1_q;
  spi_pins_t  sync2_q;
  logic       prev_clk_q;
  logic [2:0] prev_csn_q;
  logic       in_frame;
  logic       was_in_frame;

  assign raw_pins = '{clk: spi_clk_i, csn: spi_csn_i, mosi: spi_mosi_i};

  // ************************************************************
  // Two-flop synchronizer plus one history stage
  // ************************************************************

  // Idle pin state is a deselected bus with the clock low
  // The history stage keeps only the clock and the select code
  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q    <= '{clk: 1'b0, csn: CSN_IDLE, mosi: 1'b0};
      sync2_q    <= '{clk: 1'b0, csn: CSN_IDLE, mosi: 1'b0};
      prev_clk_q <= 1'b0;
      prev_csn_q <= CSN_IDLE;
    end else begin
      sync1_q    <= raw_pins;
      sync2_q    <= sync1_q;
      prev_clk_q <= sync2_q.clk;
      prev_csn_q <= sync2_q.csn;
    end
  end

  assign pins_o = sync2_q;

  // ************************************************************
  // Edge and frame strobes
  // ************************************************************

  assign in_frame     = (sync2_q.csn != CSN_IDLE);
  assign was_in_frame = (prev_csn_q != CSN_IDLE);

  // The strobes come from the second stage directly, so they line up with
  // pins_o and the pin mux can still register them in the third cycle
  assign evt_o.rise  = in_frame & sync2_q.clk & ~prev_clk_q;
  assign evt_o.fall  = in_frame & ~sync2_q.clk & prev_clk_q;
  assign evt_o.start = in_frame & ~was_in_frame;
  assign evt_o.stop  = ~in_frame & was_in_frame;

endmodule

`default_nettype wire

// ==== verilog/spi_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bit_counter
  import spi_bridge_pkg::*;
(
  input  wire              sys_clk_i,
  input  wire              arst_n_i,
  input  wire spi_evt_t    evt_i,
  output logic [CNT_W-1:0] bit_cnt_o,
  output logic             instr_done_o
);

  logic [CNT_W-1:0] cnt_q;
  logic             saturated;
  logic             last_instr_bit;

  assign saturated      = (cnt_q == CNT_W'(INSTR_BITS));
  assign last_instr_bit = (cnt_q == CNT_W'(INSTR_BITS - 1));

  // ************************************************************
  // Instruction bit counter
  // ************************************************************

  // Cleared by every frame start and held once the instruction is in,
  // so the data phase never wraps it back into the instruction range
  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (evt_i.start) begin
      cnt_q <= '0;
    end else if (evt_i.rise && !saturated) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign bit_cnt_o = cnt_q;

  // Combinational, so the FSM sees it on the same cycle as the 16th rise
  assign instr_done_o = evt_i.rise & last_instr_bit;

endmodule

`default_nettype wire

// ==== verilog/spi_dir_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_dir_fsm
  import spi_bridge_pkg::*;
(
  input  wire              sys_clk_i,
  input  wire              arst_n_i,
  input  wire spi_evt_t    evt_i,
  input  wire spi_pins_t   pins_i,
  input  wire  [CNT_W-1:0] bit_cnt_i,
  input  wire              instr_done_i,
  output logic             sdio_drive_o
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    INSTR = 2'd1,
    READ  = 2'd2,
    WRITE = 2'd3
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic       rw_q;
  logic       cap_q;
  logic       first_bit;
  logic       turn_around;
  logic [7:0] cap_map;

  // One entry per possible select code, the two unused codes read as 0
  assign cap_map = {{(8 - NUM_DEV){1'b0}}, READ_CAPABLE};

  assign first_bit   = evt_i.rise & (state_q == INSTR) & (bit_cnt_i == '0);
  assign turn_around = rw_q & cap_q;

  // ************************************************************
  // R/W bit and device capability
  // ************************************************************

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rw_q  <= 1'b0;
      cap_q <= 1'b0;
    end else if (first_bit) begin
      rw_q  <= pins_i.mosi;
      cap_q <= cap_map[pins_i.csn];
    end
  end

  // ************************************************************
  // Direction state machine
  // ************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (evt_i.start) state_d = INSTR;
      end
      INSTR: begin
        if (instr_done_i) state_d = turn_around ? READ : WRITE;
      end
      default: ;
    endcase
    // A deselect ends the transfer from any state
    if (evt_i.stop) state_d = IDLE;
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Taken from the next state so the pin mux register adds the only delay
  assign sdio_drive_o = (state_d != READ);

endmodule

`default_nettype wire

// ==== verilog/spi_pin_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_pin_mux
  import spi_bridge_pkg::*;
(
  input  wire                sys_clk_i,
  input  wire                arst_n_i,
  input  wire spi_pins_t     pins_i,
  input  wire                sdio_drive_i,
  output logic [NUM_DEV-1:0] dev_csn_o,
  output logic               spi_clk_o,
  output logic               sdio_o,
  output logic               sdio_oe_o,
  input  wire                sdio_i,
  output logic               spi_miso_o
);

  logic [NUM_DEV-1:0] csn_dec;

  // ************************************************************
  // Select decode
  // ************************************************************

  // One active-low select per device, codes 6 and 7 leave all deselected
  always_comb begin
    csn_dec = '1;
    case (pins_i.csn)
      DEV_ADC:     csn_dec[DEV_ADC]     = 1'b0;
      DEV_DAC:     csn_dec[DEV_DAC]     = 1'b0;
      DEV_CLKDIST: csn_dec[DEV_CLKDIST] = 1'b0;
      DEV_AMP:     csn_dec[DEV_AMP]     = 1'b0;
      DEV_PLL:     csn_dec[DEV_PLL]     = 1'b0;
      DEV_ATTEN:   csn_dec[DEV_ATTEN]   = 1'b0;
      default: ;
    endcase
  end

  // ************************************************************
  // Output register
  // ************************************************************

  // Selects, clock, data and enable share one register stage so the
  // devices see them with the same skew as the host produced them
  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dev_csn_o <= '1;
      spi_clk_o <= 1'b0;
      sdio_o    <= 1'b0;
      sdio_oe_o <= 1'b1;
    end else begin
      dev_csn_o <= csn_dec;
      spi_clk_o <= pins_i.clk;
      sdio_o    <= pins_i.mosi;
      sdio_oe_o <= sdio_drive_i;
    end
  end

  // Read data goes back to the host unregistered, the host samples it on
  // its own clock and the pad delay is already part of its budget
  assign spi_miso_o = sdio_i & ~sdio_oe_o;

endmodule

`default_nettype wire

// ==== verilog/board_spi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_spi_bridge
  import spi_bridge_pkg::*;
(
  input  wire                sys_clk_i,
  input  wire                arst_n_i,

  // Host SPI port
  input  wire                spi_clk_i,
  input  wire  [2:0]         spi_csn_i,
  input  wire                spi_mosi_i,
  output logic               spi_miso_o,

  // Device side, SDIO split into its pad signals
  output logic [NUM_DEV-1:0] dev_csn_o,
  output logic               spi_clk_o,
  output logic               sdio_o,
  output logic               sdio_oe_o,
  input  wire                sdio_i
);

  spi_pins_t        pins;
  spi_evt_t         evt;
  logic [CNT_W-1:0] bit_cnt;
  logic             instr_done;
  logic             sdio_drive;

  // ************************************************************
  // Input side
  // ************************************************************

  spi_edge_sync i_edge_sync (
    .sys_clk_i  (sys_clk_i),
    .arst_n_i   (arst_n_i),
    .spi_clk_i  (spi_clk_i),
    .spi_csn_i  (spi_csn_i),
    .spi_mosi_i (spi_mosi_i),
    .pins_o     (pins),
    .evt_o      (evt));

  spi_bit_counter i_bit_counter (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .evt_i        (evt),
    .bit_cnt_o    (bit_cnt),
    .instr_done_o (instr_done));

  // ************************************************************
  // Direction control and pins
  // ************************************************************

  spi_dir_fsm i_dir_fsm (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .evt_i        (evt),
    .pins_i       (pins),
    .bit_cnt_i    (bit_cnt),
    .instr_done_i (instr_done),
    .sdio_drive_o (sdio_drive));

  spi_pin_mux i_pin_mux (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .pins_i       (pins),
    .sdio_drive_i (sdio_drive),
    .dev_csn_o    (dev_csn_o),
    .spi_clk_o    (spi_clk_o),
    .sdio_o       (sdio_o),
    .sdio_oe_o    (sdio_oe_o),
    .sdio_i       (sdio_i),
    .spi_miso_o   (spi_miso_o));

endmodule

`default_nettype wire

// ==== sim/tb_spi_host.svh ====
`ifndef TB_SPI_HOST_SVH
`define TB_SPI_HOST_SVH

// Holds the present SPI level for 4 to 7 system clocks
task automatic hold_level();
  logic [31:0] r;
  r = $random(seed);
  repeat (4 + r[1:0]) @(posedge sys_clk);
endtask

// ************************************************************
// Host SPI master
// ************************************************************

// Mode 0 frame, MSB first, with len data bits after the instruction
// Read data is taken at the end of each high level
task automatic spi_frame(input logic [2:0] code, input logic [15:0] instr,
                         input int len, output logic [15:0] rd_word);
  logic [31:0] r;
  int          i;
  rd_word = '0;
  spi_csn <= code;
  hold_level();
  for (i = 0; i < INSTR_BITS + len; i++) begin
    r = $random(seed);
    if (i < INSTR_BITS) begin
      spi_mosi <= instr[INSTR_BITS - 1 - i];
    end else begin
      spi_mosi <= r[0];
    end
    hold_level();
    spi_clk <= 1'b1;
    hold_level();
    if (i >= INSTR_BITS) rd_word = {rd_word[14:0], spi_miso};
    spi_clk <= 1'b0;
  end
  hold_level();
  spi_csn  <= CSN_IDLE;
  spi_mosi <= 1'b0;
  hold_level();
  host_busy = 1'b0;
endtask

// ************************************************************
// Device answering a read
// ************************************************************

// Shifts word out MSB first on the falling device clock once the bridge
// has released SDIO, then lets the line float back high
task automatic device_reply(input logic [15:0] word, input int len);
  int i;
  while (sdio_oe && host_busy) @(posedge sys_clk);
  if (sdio_oe) begin
    frame_errors++;
    $display("Device model saw the frame end without the SDIO line being released");
  end else begin
    for (i = len - 1; i >= 0; i--) begin
      while (dev_clk !== 1'b0) @(posedge sys_clk);
      sdio_in <= word[i];
      while (dev_clk !== 1'b1) @(posedge sys_clk);
    end
    while (!sdio_oe) @(posedge sys_clk);
    sdio_in <= 1'b1;
  end
endtask

`endif

// ==== sim/tb_board_spi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_spi_bridge
  import spi_bridge_pkg::*;
();

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 8;
  localparam int NUM_FRAMES    = 34;
  // A 32-bit frame at the longest hold plus select setup and hold
  localparam int FRAME_MAX_CYC = 520;
  localparam int WATCHDOG_CYC  = RESET_CYCLES + NUM_FRAMES * FRAME_MAX_CYC + 200;
  localparam spi_pins_t IDLE_PINS = '{clk: 1'b0, csn: CSN_IDLE, mosi: 1'b0};

  logic               sys_clk;
  logic               arst_n;
  logic               spi_clk;
  logic [2:0]         spi_csn;
  logic               spi_mosi;
  logic               spi_miso;
  logic [NUM_DEV-1:0] dev_csn;
  logic               dev_clk;
  logic               sdio_out;
  logic               sdio_oe;
  logic               sdio_in;

  integer     seed;
  logic       host_busy;
  int         frames;
  int         signal_errors;
  int         frame_errors;
  spi_pins_t  pin_pipe [3];
  logic [1:0] oe_pipe;
  logic       oe_model;
  logic       ref_clk_q;
  logic [4:0] ref_cnt;
  logic       ref_rw;

  board_spi_bridge board_spi_bridge_i (
    .sys_clk_i  (sys_clk),
    .arst_n_i   (arst_n),
    .spi_clk_i  (spi_clk),
    .spi_csn_i  (spi_csn),
    .spi_mosi_i (spi_mosi),
    .spi_miso_o (spi_miso),
    .dev_csn_o  (dev_csn),
    .spi_clk_o  (dev_clk),
    .sdio_o     (sdio_out),
    .sdio_oe_o  (sdio_oe),
    .sdio_i     (sdio_in));

  function automatic logic [NUM_DEV-1:0] expected_selects(input logic [2:0] code);
    logic [NUM_DEV-1:0] sel;
    sel = '1;
    if (int'(code) < NUM_DEV) sel[code] = 1'b0;
    return sel;
  endfunction

  // The ADC, DAC and clock distributor drive read data back on SDIO
  function automatic logic answers_reads(input logic [2:0] code);
    return code == DEV_ADC || code == DEV_DAC || code == DEV_CLKDIST;
  endfunction

  `include "tb_spi_host.svh"

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // ************************************************************
  // Expected pins from the raw host side
  // ************************************************************

  // The pipe gives the raw pins three cycles late
  // The enable model lags one cycle and oe_pipe adds the other two
  always @(posedge sys_clk or negedge arst_n) begin
    if (!arst_n) begin
      pin_pipe[0] <= IDLE_PINS;
      pin_pipe[1] <= IDLE_PINS;
      pin_pipe[2] <= IDLE_PINS;
      oe_pipe     <= 2'b11;
      oe_model    <= 1'b1;
      ref_clk_q   <= 1'b0;
      ref_cnt     <= '0;
      ref_rw      <= 1'b0;
    end else begin
      pin_pipe[0] <= '{clk: spi_clk, csn: spi_csn, mosi: spi_mosi};
      pin_pipe[1] <= pin_pipe[0];
      pin_pipe[2] <= pin_pipe[1];
      oe_pipe     <= {oe_pipe[0], oe_model};
      ref_clk_q   <= spi_clk;
      if (spi_csn == CSN_IDLE) begin
        ref_cnt  <= '0;
        oe_model <= 1'b1;
      end else if (spi_clk && !ref_clk_q) begin
        if (ref_cnt == 5'd0) ref_rw <= spi_mosi;
        if (ref_cnt < 5'd16) ref_cnt <= ref_cnt + 5'd1;
        // Sixteenth rising edge closes the instruction
        if (ref_cnt == 5'd15 && ref_rw && answers_reads(spi_csn)) oe_model <= 1'b0;
      end
    end
  end

  a_clk_delay: assert property (@(posedge sys_clk) disable iff (!arst_n)
    dev_clk == pin_pipe[2].clk)
    else begin
      signal_errors++;
      $display("CHECK FAILED spi_clk_o exp=%h got=%h", $sampled(pin_pipe[2].clk),
               $sampled(dev_clk));
    end

  a_data_delay: assert property (@(posedge sys_clk) disable iff (!arst_n)
    sdio_out == pin_pipe[2].mosi)
    else begin
      signal_errors++;
      $display("CHECK FAILED sdio_o exp=%h got=%h", $sampled(pin_pipe[2].mosi),
               $sampled(sdio_out));
    end

  a_select_decode: assert property (@(posedge sys_clk) disable iff (!arst_n)
    dev_csn == expected_selects(pin_pipe[2].csn))
    else begin
      signal_errors++;
      $display("CHECK FAILED dev_csn_o exp=%h got=%h",
               expected_selects($sampled(pin_pipe[2].csn)), $sampled(dev_csn));
    end

  a_idle_bus: assert property (@(posedge sys_clk) disable iff (!arst_n)
    (pin_pipe[2].csn == CSN_IDLE) |-> (dev_csn == '1 && sdio_oe))
    else begin
      signal_errors++;
      $display("CHECK FAILED {dev_csn_o,sdio_oe_o} exp=%h got=%h", 7'h7f,
               $sampled({dev_csn, sdio_oe}));
    end

  a_turnaround: assert property (@(posedge sys_clk) disable iff (!arst_n)
    sdio_oe == oe_pipe[1])
    else begin
      signal_errors++;
      $display("CHECK FAILED sdio_oe_o exp=%h got=%h", $sampled(oe_pipe[1]),
               $sampled(sdio_oe));
    end

  // Read data reaches the host only while the model has released the line
  a_miso_path: assert property (@(posedge sys_clk) disable iff (!arst_n)
    spi_miso == (oe_pipe[1] ? 1'b0 : sdio_in))
    else begin
      signal_errors++;
      $display("CHECK FAILED spi_miso_o exp=%h got=%h",
               $sampled(oe_pipe[1] ? 1'b0 : sdio_in), $sampled(spi_miso));
    end

  // ************************************************************
  // Stimulus
  // ************************************************************

  task automatic run_transfer(input logic [2:0] code, input logic rw, input int len);
    logic [31:0] r;
    logic [15:0] word;
    logic [15:0] rd_word;
    logic [15:0] exp_word;
    r         = $random(seed);
    word      = r[31:16];
    exp_word  = (len == 8) ? {8'h00, word[7:0]} : word;
    host_busy = 1'b1;
    if (rw && answers_reads(code)) begin
      fork
        spi_frame(code, {rw, r[14:0]}, len, rd_word);
        device_reply(word, len);
      join
      a_read_word: assert (rd_word == exp_word) else begin
        frame_errors++;
        $display("CHECK FAILED spi_miso_o read word exp=%h got=%h", exp_word, rd_word);
      end
    end else begin
      spi_frame(code, {rw, r[14:0]}, len, rd_word);
    end
    frames++;
  endtask

  initial begin
    logic [31:0] r;
    int          i;
    seed          = 32924;
    frames        = 0;
    signal_errors = 0;
    frame_errors  = 0;
    host_busy     = 1'b0;
    arst_n        = 1'b0;
    spi_clk       = 1'b0;
    spi_csn       = CSN_IDLE;
    spi_mosi      = 1'b0;
    sdio_in       = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    a_reset_state: assert ({dev_csn, dev_clk, sdio_out, sdio_oe, spi_miso} == 10'h3f2)
      else begin
        frame_errors++;
        $display("CHECK FAILED {dev_csn_o,spi_clk_o,sdio_o,sdio_oe_o,spi_miso_o} exp=%h got=%h",
                 10'h3f2, {dev_csn, dev_clk, sdio_out, sdio_oe, spi_miso});
      end
    arst_n <= 1'b1;
    repeat (4) @(posedge sys_clk);
    // Code 7 clocks the bus with nothing selected
    for (i = 0; i < 8; i++) begin
      run_transfer(3'(i), 1'b1, 16);
      run_transfer(3'(i), 1'b0, 16);
    end
    for (i = 16; i < NUM_FRAMES; i++) begin
      r = $random(seed);
      run_transfer(r[2:0], r[3], r[4] ? 16 : 8);
    end
    repeat (8) @(posedge sys_clk);
    $display("Summary: %0d frames, %0d signal errors, %0d frame errors",
             frames, signal_errors, frame_errors);
    if (signal_errors == 0 && frame_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge sys_clk);
    $display("Watchdog expired after %0d cycles before all frames were sent", WATCHDOG_CYC);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
verilog/spi_bridge_pkg.sv
verilog/spi_edge_sync.sv
verilog/spi_bit_counter.sv
verilog/spi_dir_fsm.sv
verilog/spi_pin_mux.sv
verilog/board_spi_bridge.sv
sim/tb_board_spi_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SPI bridge testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_board_spi_bridge
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" -f vlog.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
